//--- qla_motor.f
+incdir+include
src/qla_pkg.sv
src/reg_write_decode.sv
src/safety_check.sv
src/motor_channel.sv
src/reg_read_mux.sv
src/qla_motor_top.sv
testbench/tb_clock_gen.sv
testbench/tb_qla_motor.sv

//--- Bender.yml
package:
  name: qla_motor

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/qla_pkg.sv
      - src/reg_write_decode.sv
      - src/safety_check.sv
      - src/motor_channel.sv
      - src/reg_read_mux.sv
      - src/qla_motor_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_qla_motor.sv

//--- testbench/tb_qla_motor.sv
`include "qla_params.svh"

module tb_qla_motor
    import qla_pkg::*;
();

    typedef enum logic [2:0] {OP_WR, OP_BLK, OP_RD, OP_HOLD, OP_DAC} op_e;

    // one table row
    // exp carries read data or the pin vector or the pulse flag
    typedef struct packed {
        op_e                          op;
        logic [`QLA_ADDR_W-1:0]       addr;
        reg_word_u                    wdata;
        logic signed [`QLA_CUR_W-1:0] fb;       // addressed axis only
        logic [`QLA_NUM_CHAN-1:0]     fault;
        logic                         busy;
        logic [7:0]                   n;        // hold or watch cycles
        reg_word_u                    exp;
    } entry_t;

    logic                         sysclk;
    logic                         rst_n;
    logic                         reg_wen;
    logic                         blk_wen;
    logic [`QLA_ADDR_W-1:0]       reg_waddr;
    reg_word_u                    reg_wdata;
    logic [`QLA_ADDR_W-1:0]       reg_raddr;
    logic [`QLA_DATA_W-1:0]       reg_rdata;
    logic signed [`QLA_CUR_W-1:0] cur_fb  [`QLA_NUM_CHAN];
    logic signed [`QLA_CUR_W-1:0] cur_cmd [`QLA_NUM_CHAN];
    logic [`QLA_NUM_CHAN-1:0]     amp_fault;
    logic [`QLA_NUM_CHAN-1:0]     amp_disable_pin;
    logic                         dac_busy;
    logic                         dac_update;

    entry_t      table_q [$];
    int          err_cnt;
    int          check_cnt;
    int          waited;
    logic [31:0] cmd_val [`QLA_NUM_CHAN];   // last random writes per axis
    logic [31:0] cfg_val [`QLA_NUM_CHAN];

    tb_clock_gen i_clk (.sysclk(sysclk), .rst_n(rst_n));

    qla_motor_top i_dut (
        .sysclk(sysclk), .rst_n(rst_n),
        .reg_wen(reg_wen), .blk_wen(blk_wen), .reg_waddr(reg_waddr),
        .reg_wdata(reg_wdata), .reg_raddr(reg_raddr), .reg_rdata(reg_rdata),
        .cur_fb(cur_fb), .amp_fault(amp_fault), .cur_cmd(cur_cmd),
        .amp_disable_pin(amp_disable_pin), .dac_busy(dac_busy), .dac_update(dac_update)
    );

    // ----------------------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------------------
    task automatic check_word(input reg_word_u got, input reg_word_u exp, input string msg);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %0t %s: got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_cmd(input logic signed [`QLA_CUR_W-1:0] got,
                             input logic signed [`QLA_CUR_W-1:0] exp, input string msg);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %0t %s: got %0d expected %0d", $time, msg, got, exp);
        end
    endtask

    task automatic check_pins(input logic [`QLA_NUM_CHAN-1:0] got,
                              input logic [`QLA_NUM_CHAN-1:0] exp, input string msg);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %0t %s: got %b expected %b", $time, msg, got, exp);
        end
    endtask

    task automatic check_pulse(input logic got, input logic exp, input string msg);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %0t %s: seen %b expected %b", $time, msg, got, exp);
        end
    endtask

    // ----------------------------------------------------------------------
    // table building
    // ----------------------------------------------------------------------
    function automatic logic [`QLA_ADDR_W-1:0] addr_of(input logic [3:0] space,
                                                       input int chan, input logic [3:0] off);
        return {space, 4'h0, 4'(chan), off};
    endfunction

    task automatic push_entry(input op_e op, input logic [`QLA_ADDR_W-1:0] addr,
                              input logic [31:0] wdata, input logic signed [15:0] fb,
                              input logic [3:0] fault, input logic busy, input int n,
                              input logic [31:0] exp);
        entry_t e;
        e.op = op;
        e.addr = addr;
        e.wdata = wdata;
        e.fb = fb;
        e.fault = fault;
        e.busy = busy;
        e.n = 8'(n);
        e.exp = exp;
        table_q.push_back(e);
    endtask

    task automatic build_table();
        logic [31:0] d;
        // after reset all registers read zero with amps off and no update
        for (int c = 1; c <= `QLA_NUM_CHAN; c++) begin
            push_entry(OP_RD, addr_of(`QLA_ADDR_MAIN, c, `QLA_OFF_DAC_CTRL), 0, 0, 0, 0, 0, 0);
            push_entry(OP_RD, addr_of(`QLA_ADDR_MAIN, c, `QLA_OFF_MOTOR_CONFIG), 0, 0, 0, 0, 0, 0);
        end
        push_entry(OP_HOLD, addr_of(`QLA_ADDR_MAIN, 0, `QLA_OFF_STATUS), 0, 0, 0, 0, 1, 32'hF);
        push_entry(OP_DAC, addr_of(`QLA_ADDR_MAIN, 0, `QLA_OFF_STATUS), 0, 0, 0, 0, 4, 0);
        // random command and config read back sign extended
        for (int c = 1; c <= `QLA_NUM_CHAN; c++) begin
            d = $urandom;
            cmd_val[c-1] = d;
            push_entry(OP_WR, addr_of(`QLA_ADDR_MAIN, c, `QLA_OFF_DAC_CTRL), d, 0, 0, 0, 0, 0);
            push_entry(OP_RD, addr_of(`QLA_ADDR_MAIN, c, `QLA_OFF_DAC_CTRL), 0, 0, 0, 0, 0,
                       {{16{d[15]}}, d[15:0]});
            d = $urandom;
            cfg_val[c-1] = d;
            push_entry(OP_WR, addr_of(`QLA_ADDR_MAIN, c, `QLA_OFF_MOTOR_CONFIG), d, 0, 0, 0, 0, 0);
            push_entry(OP_RD, addr_of(`QLA_ADDR_MAIN, c, `QLA_OFF_MOTOR_CONFIG), 0, 0, 0, 0, 0,
                       {29'd0, d[2:0]});
        end
        // other axes untouched by each write
        for (int c = 1; c <= `QLA_NUM_CHAN; c++) begin
            d = cmd_val[c-1];
            push_entry(OP_RD, addr_of(`QLA_ADDR_MAIN, c, `QLA_OFF_DAC_CTRL), 0, 0, 0, 0, 0,
                       {{16{d[15]}}, d[15:0]});
            push_entry(OP_RD, addr_of(`QLA_ADDR_MAIN, c, `QLA_OFF_MOTOR_CONFIG), 0, 0, 0, 0, 0,
                       {29'd0, cfg_val[c-1][2:0]});
        end
        push_entry(OP_RD, addr_of(`QLA_ADDR_MAIN, 5, `QLA_OFF_DAC_CTRL), 0, 0, 0, 0, 0, 0);
        push_entry(OP_WR, addr_of(4'h1, 1, `QLA_OFF_DAC_CTRL), 32'h1234_5678, 0, 0, 0, 0, 0);
        push_entry(OP_RD, addr_of(4'h1, 1, `QLA_OFF_DAC_CTRL), 0, 0, 0, 0, 0, 0);
        d = cmd_val[0];
        push_entry(OP_RD, addr_of(`QLA_ADDR_MAIN, 1, `QLA_OFF_DAC_CTRL), 0, 0, 0, 0, 0,
                   {{16{d[15]}}, d[15:0]});
        // dac update held off by busy and then exactly one pulse
        push_entry(OP_BLK, addr_of(`QLA_ADDR_MAIN, 1, `QLA_OFF_DAC_CTRL), 32'h200, 0, 0, 1, 0, 0);
        push_entry(OP_DAC, addr_of(`QLA_ADDR_MAIN, 0, 0), 0, 0, 0, 1, 6, 0);
        push_entry(OP_DAC, addr_of(`QLA_ADDR_MAIN, 0, 0), 0, 0, 0, 0, 10, 1);
        push_entry(OP_WR, addr_of(`QLA_ADDR_MAIN, 1, `QLA_OFF_DAC_CTRL), 32'h300, 0, 0, 0, 0, 0);
        push_entry(OP_DAC, addr_of(`QLA_ADDR_MAIN, 0, 0), 0, 0, 0, 0, 10, 0);
        // safety on axis 2 where cmd 100 gives a limit of 400
        for (int c = 1; c <= `QLA_NUM_CHAN; c++) begin
            if (c != 2) begin
                push_entry(OP_WR, addr_of(`QLA_ADDR_MAIN, c, `QLA_OFF_MOTOR_CONFIG),
                           0, 0, 0, 0, 0, 0);
            end
        end
        push_entry(OP_WR, addr_of(`QLA_ADDR_MAIN, 2, `QLA_OFF_DAC_CTRL), 100, 0, 0, 0, 0, 0);
        push_entry(OP_WR, addr_of(`QLA_ADDR_MAIN, 2, `QLA_OFF_MOTOR_CONFIG), 5, 0, 0, 0, 0, 0);
        push_entry(OP_HOLD, addr_of(`QLA_ADDR_MAIN, 2, 0), 0, 0, 0, 0, 1, 4'b1101);
        push_entry(OP_HOLD, addr_of(`QLA_ADDR_MAIN, 2, 0), 0, 1000, 0, 0,
                   `QLA_SAFETY_COUNT - 1, 4'b1101);
        push_entry(OP_HOLD, addr_of(`QLA_ADDR_MAIN, 2, 0), 0, -1000, 0, 0,
                   `QLA_SAFETY_COUNT - 1, 4'b1101);    // run broken by the settle cycle
        push_entry(OP_HOLD, addr_of(`QLA_ADDR_MAIN, 2, 0), 0, -1000, 0, 0,
                   `QLA_SAFETY_COUNT, 4'b1111);
        push_entry(OP_RD, addr_of(`QLA_ADDR_MAIN, 0, `QLA_OFF_STATUS), 0, 0, 0, 0, 0, 32'hF2);
        push_entry(OP_RD, addr_of(`QLA_ADDR_MAIN, 2, `QLA_OFF_MOTOR_STATUS), 0, 16'h0123,
                   4'b0010, 0, 0, 32'h0123_0147);
        push_entry(OP_WR, addr_of(`QLA_ADDR_MAIN, 2, `QLA_OFF_MOTOR_CONFIG), 5, 0, 0, 0, 0, 0);
        push_entry(OP_HOLD, addr_of(`QLA_ADDR_MAIN, 2, 0), 0, 0, 0, 0, 1, 4'b1101);
        push_entry(OP_RD, addr_of(`QLA_ADDR_MAIN, 0, `QLA_OFF_STATUS), 0, 0, 0, 0, 0, 32'hD0);
        // check skipped in debug mode and in voltage mode
        push_entry(OP_WR, addr_of(`QLA_ADDR_MAIN, 2, `QLA_OFF_MOTOR_CONFIG), 7, 0, 0, 0, 0, 0);
        push_entry(OP_HOLD, addr_of(`QLA_ADDR_MAIN, 2, 0), 0, 1000, 0, 0, 12, 4'b1101);
        push_entry(OP_WR, addr_of(`QLA_ADDR_MAIN, 2, `QLA_OFF_MOTOR_CONFIG), 1, 0, 0, 0, 0, 0);
        push_entry(OP_HOLD, addr_of(`QLA_ADDR_MAIN, 2, 0), 0, 1000, 0, 0, 12, 4'b1101);
        push_entry(OP_RD, addr_of(`QLA_ADDR_MAIN, 0, `QLA_OFF_STATUS), 0, 0, 0, 0, 0, 32'hD0);
        push_entry(OP_RD, addr_of(`QLA_ADDR_MAIN, 3, `QLA_OFF_MOTOR_STATUS), 0, 16'h0040,
                   4'b0100, 0, 0, 32'h0040_0005);
    endtask

    // ----------------------------------------------------------------------
    // apply one row between two falling edges
    // ----------------------------------------------------------------------
    task automatic run_entry(input entry_t e, input int idx);
        int   errs_before;
        int   ch;
        int   cyc;
        logic seen;
        logic again;
        errs_before = err_cnt;
        ch = int'(e.addr[`QLA_CHAN_RNG]) - 1;
        for (int i = 0; i < `QLA_NUM_CHAN; i++) begin
            cur_fb[i] = (i == ch) ? e.fb : '0;
        end
        amp_fault = e.fault;
        dac_busy  = e.busy;
        case (e.op)
            OP_WR, OP_BLK: begin
                reg_wen   = 1'b1;
                blk_wen   = (e.op == OP_BLK);
                reg_waddr = e.addr;
                reg_wdata = e.wdata;
                @(posedge sysclk);
                @(negedge sysclk);
                reg_wen = 1'b0;
                blk_wen = 1'b0;
            end
            OP_RD: begin
                reg_raddr = e.addr;
                @(posedge sysclk);              // raddr sampled here
                @(negedge sysclk);
                check_word(reg_rdata, e.exp, $sformatf("read %h", e.addr));
                if (e.addr[`QLA_SPACE_RNG] == `QLA_ADDR_MAIN && ch >= 0 && ch < `QLA_NUM_CHAN
                    && e.addr[`QLA_OFF_RNG] == `QLA_OFF_DAC_CTRL) begin
                    check_cmd(cur_cmd[ch], e.exp.dac.cur_cmd, $sformatf("cur_cmd[%0d]", ch));
                end
            end
            OP_HOLD: begin
                repeat (e.n) begin
                    @(posedge sysclk);
                    @(negedge sysclk);
                end
                for (int i = 0; i < `QLA_NUM_CHAN; i++) begin
                    cur_fb[i] = '0;             // back under the limit
                end
                @(posedge sysclk);              // pin is one more register
                @(negedge sysclk);
                check_pins(amp_disable_pin, e.exp[`QLA_NUM_CHAN-1:0], "amp_disable_pin");
            end
            default: begin
                seen = 1'b0;
                cyc  = 0;
                while (!seen && cyc < e.n) begin
                    @(posedge sysclk);
                    @(negedge sysclk);
                    seen = dac_update;
                    cyc++;
                end
                if (e.exp[0] && !seen) begin
                    err_cnt++;
                    $display("timeout: dac_update did not arrive within %0d cycles", e.n);
                end else begin
                    check_pulse(seen, e.exp[0], "dac_update");
                end
                if (seen) begin
                    again = 1'b0;
                    repeat (e.n) begin
                        @(posedge sysclk);
                        @(negedge sysclk);
                        again = again | dac_update;
                    end
                    check_pulse(again, 1'b0, "second dac_update");
                end
            end
        endcase
        $display("test %0d %s addr %h: %s", idx, e.op.name(), e.addr,
                 (err_cnt == errs_before) ? "ok" : "error");
    endtask

    initial begin
        reg_wen   = 1'b0;
        blk_wen   = 1'b0;
        reg_waddr = '0;
        reg_wdata = '0;
        reg_raddr = '0;
        amp_fault = '0;
        dac_busy  = 1'b0;
        for (int i = 0; i < `QLA_NUM_CHAN; i++) begin
            cur_fb[i] = '0;
        end
        err_cnt   = 0;
        check_cnt = 0;
        void'($urandom(46));
        build_table();
        waited = 0;
        while (rst_n !== 1'b1 && waited < 20) begin
            @(posedge sysclk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            err_cnt++;
            $display("timeout: reset was never released");
        end
        @(negedge sysclk);
        foreach (table_q[i]) begin
            run_entry(table_q[i], i);
        end
        $display("%0d tests, %0d checks, %0d errors", table_q.size(), check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- testbench/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD       = 100,   // time units per clock
    parameter int RESET_CYCLES = 2
) (
    output logic sysclk,
    output logic rst_n
);

    // free running clock
    initial begin
        sysclk = 1'b0;
        forever #(PERIOD / 2) sysclk = ~sysclk;
    end

    // reset low over the first rising edges, released off a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge sysclk);
        @(negedge sysclk);
        rst_n = 1'b1;
    end

endmodule

//--- src/qla_motor_top.sv
`include "qla_params.svh"

module qla_motor_top
    import qla_pkg::*;
(
    input  logic                         sysclk,
    input  logic                         rst_n,

    // host register bus
    input  logic                         reg_wen,
    input  logic                         blk_wen,
    input  logic [`QLA_ADDR_W-1:0]       reg_waddr,
    input  reg_word_u                    reg_wdata,
    input  logic [`QLA_ADDR_W-1:0]       reg_raddr,
    output logic [`QLA_DATA_W-1:0]       reg_rdata,     // one cycle after raddr

    // motor side
    input  logic signed [`QLA_CUR_W-1:0] cur_fb [`QLA_NUM_CHAN],   // parallel adc words
    input  logic [`QLA_NUM_CHAN-1:0]     amp_fault,
    output logic signed [`QLA_CUR_W-1:0] cur_cmd [`QLA_NUM_CHAN],  // to dac engine
    output logic [`QLA_NUM_CHAN-1:0]     amp_disable_pin,

    // dac engine handshake
    input  logic                         dac_busy,
    output logic                         dac_update
);

    logic [`QLA_NUM_CHAN-1:0] dac_wen;      // per axis write strobes
    logic [`QLA_NUM_CHAN-1:0] cfg_wen;
    reg_word_u                chan_cfg    [`QLA_NUM_CHAN];
    logic [`QLA_DATA_W-1:0]   chan_status [`QLA_NUM_CHAN];
    logic [`QLA_NUM_CHAN-1:0] chan_safety;  // safety trips

    // ---------------------------------------------------------------------
    // write side
    // ---------------------------------------------------------------------
    reg_write_decode i_wdec (
        .sysclk     (sysclk),
        .rst_n      (rst_n),
        .reg_wen    (reg_wen),
        .blk_wen    (blk_wen),
        .reg_waddr  (reg_waddr),
        .dac_busy   (dac_busy),
        .dac_wen    (dac_wen),
        .cfg_wen    (cfg_wen),
        .dac_update (dac_update)      // dac engine loads all axes
    );

    // ---------------------------------------------------------------------
    // motor channels, axis k at channel address k+1
    // ---------------------------------------------------------------------
    for (genvar ch = 0; ch < `QLA_NUM_CHAN; ch++) begin : g_chan
        motor_channel i_chan (
            .sysclk          (sysclk),
            .rst_n           (rst_n),
            .dac_wen         (dac_wen[ch]),
            .cfg_wen         (cfg_wen[ch]),
            .reg_wdata       (reg_wdata),       // shared, strobes pick the axis
            .cur_fb          (cur_fb[ch]),
            .amp_fault       (amp_fault[ch]),
            .cur_cmd         (cur_cmd[ch]),
            .cfg             (chan_cfg[ch]),
            .motor_status    (chan_status[ch]),
            .safety_disable  (chan_safety[ch]),
            .amp_disable_pin (amp_disable_pin[ch])
        );
    end

    // ---------------------------------------------------------------------
    // read side
    // ---------------------------------------------------------------------
    reg_read_mux i_rmux (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .reg_raddr    (reg_raddr),
        .chan_cur_cmd (cur_cmd),
        .chan_cfg     (chan_cfg),
        .chan_status  (chan_status),
        .chan_safety  (chan_safety),
        .chan_amp_pin (amp_disable_pin),
        .reg_rdata    (reg_rdata)
    );

endmodule

//--- src/reg_read_mux.sv
`include "qla_params.svh"

module reg_read_mux
    import qla_pkg::*;
(
    input  logic                         sysclk,
    input  logic                         rst_n,
    input  logic [`QLA_ADDR_W-1:0]       reg_raddr,
    input  logic signed [`QLA_CUR_W-1:0] chan_cur_cmd [`QLA_NUM_CHAN],
    input  reg_word_u                    chan_cfg     [`QLA_NUM_CHAN],
    input  logic [`QLA_DATA_W-1:0]       chan_status  [`QLA_NUM_CHAN],
    input  logic [`QLA_NUM_CHAN-1:0]     chan_safety,     // trips, per axis
    input  logic [`QLA_NUM_CHAN-1:0]     chan_amp_pin,    // disable pins
    output logic [`QLA_DATA_W-1:0]       reg_rdata
);

    localparam int PAD_W = `QLA_DATA_W - `QLA_CUR_W;   // sign extension

    logic [`QLA_FIELD_W-1:0] space;
    logic [`QLA_FIELD_W-1:0] chan;
    logic [`QLA_FIELD_W-1:0] offset;
    logic [`QLA_DATA_W-1:0]  rd_next;

    assign space  = reg_raddr[`QLA_SPACE_RNG];
    assign chan   = reg_raddr[`QLA_CHAN_RNG];
    assign offset = reg_raddr[`QLA_OFF_RNG];

    // ---------------------------------------------------------------------
    // select
    // ---------------------------------------------------------------------
    always_comb begin
        rd_next = '0;                           // unmapped reads give zero
        if (space == `QLA_ADDR_MAIN) begin
            // board status, safety trips low nibble, amp pins above
            if (chan == '0 && offset == `QLA_OFF_STATUS) begin
                rd_next = `QLA_DATA_W'({chan_amp_pin, chan_safety});
            end
            for (int i = 0; i < `QLA_NUM_CHAN; i++) begin
                if (chan == `QLA_FIELD_W'(i + 1)) begin
                    case (offset)
                        `QLA_OFF_DAC_CTRL:
                            rd_next = {{PAD_W{chan_cur_cmd[i][`QLA_CUR_W-1]}},
                                       chan_cur_cmd[i]};
                        `QLA_OFF_MOTOR_CONFIG: rd_next = chan_cfg[i];
                        `QLA_OFF_MOTOR_STATUS: rd_next = chan_status[i];
                        default:               rd_next = '0;
                    endcase
                end
            end
        end
    end

    // one cycle read latency
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            reg_rdata <= '0;
        end else begin
            reg_rdata <= rd_next;
        end
    end

endmodule

//--- src/motor_channel.sv
`include "qla_params.svh"

module motor_channel
    import qla_pkg::*;
(
    input  logic                          sysclk,
    input  logic                          rst_n,
    input  logic                          dac_wen,          // DAC_CTRL write, this axis
    input  logic                          cfg_wen,          // MOTOR_CONFIG write
    input  reg_word_u                     reg_wdata,
    input  logic signed [`QLA_CUR_W-1:0]  cur_fb,           // adc feedback
    input  logic                          amp_fault,        // from the amp
    output logic signed [`QLA_CUR_W-1:0]  cur_cmd,          // to the dac engine
    output reg_word_u                     cfg,
    output logic [`QLA_DATA_W-1:0]        motor_status,
    output logic                          safety_disable,
    output logic                          amp_disable_pin   // high = amp off
);

    logic enable_check;
    logic clear_disable;

    // ---------------------------------------------------------------------
    // command and config registers
    // ---------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            cur_cmd <= '0;
            cfg     <= '0;      // amp off, voltage mode
        end else begin
            if (dac_wen) begin
                cur_cmd <= reg_wdata.dac.cur_cmd;
            end
            if (cfg_wen) begin
                // reserved bits stay zero
                cfg.cfg.amp_enable     <= reg_wdata.cfg.amp_enable;
                cfg.cfg.disable_safety <= reg_wdata.cfg.disable_safety;
                cfg.cfg.cur_ctrl       <= reg_wdata.cfg.cur_ctrl;
            end
        end
    end

    // check only makes sense while the current loop is closed
    assign enable_check  = cfg.cfg.cur_ctrl & ~cfg.cfg.disable_safety;
    assign clear_disable = cfg_wen & reg_wdata.cfg.amp_enable;   // re-enable clears trip

    safety_check i_safety (
        .sysclk         (sysclk),
        .rst_n          (rst_n),
        .cur_fb         (cur_fb),
        .cur_cmd        (cur_cmd),
        .enable_check   (enable_check),
        .clear_disable  (clear_disable),
        .safety_disable (safety_disable)
    );

    // ---------------------------------------------------------------------
    // amplifier pin and status word
    // ---------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            amp_disable_pin <= 1'b1;        // amp held off out of reset
        end else begin
            amp_disable_pin <= ~cfg.cfg.amp_enable | safety_disable;
        end
    end

    assign motor_status = {cur_fb,                  // 31:16
                           7'd0,
                           cfg.cfg.cur_ctrl,        // 8
                           cfg.cfg.disable_safety,  // 7
                           cfg.cfg.amp_enable,      // 6
                           3'd0,
                           amp_fault,               // 2
                           safety_disable,          // 1
                           amp_disable_pin};        // 0

endmodule

//--- src/safety_check.sv
`include "qla_params.svh"

module safety_check (
    input  logic                         sysclk,
    input  logic                         rst_n,
    input  logic signed [`QLA_CUR_W-1:0] cur_fb,          // measured current
    input  logic signed [`QLA_CUR_W-1:0] cur_cmd,         // commanded current
    input  logic                         enable_check,    // current mode, check on
    input  logic                         clear_disable,   // host re-enable
    output logic                         safety_disable   // latched trip
);

    localparam int LIM_W = `QLA_SAFETY_LIM_W;
    localparam int CNT_W = `QLA_SAFETY_CNT_W;
    localparam logic [CNT_W-1:0] TRIP_CNT = CNT_W'(`QLA_SAFETY_COUNT - 1);

    logic [`QLA_CUR_W:0] fb_ext;        // sign extended, -32768 needs the bit
    logic [`QLA_CUR_W:0] cmd_ext;
    logic [`QLA_CUR_W:0] fb_mag;
    logic [`QLA_CUR_W:0] cmd_mag;
    logic [LIM_W-1:0]    limit;         // 2*|cmd| + margin
    logic                over_limit;
    logic [CNT_W-1:0]    over_cnt;      // samples over limit in a row

    // magnitudes and the limit compare
    always_comb begin
        fb_ext     = {cur_fb[`QLA_CUR_W-1], cur_fb};
        cmd_ext    = {cur_cmd[`QLA_CUR_W-1], cur_cmd};
        fb_mag     = fb_ext[`QLA_CUR_W] ? (~fb_ext + 1'b1) : fb_ext;
        cmd_mag    = cmd_ext[`QLA_CUR_W] ? (~cmd_ext + 1'b1) : cmd_ext;
        limit      = LIM_W'({cmd_mag, 1'b0}) + LIM_W'(`QLA_SAFETY_MARGIN);
        over_limit = LIM_W'(fb_mag) > limit;
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            over_cnt       <= '0;
            safety_disable <= 1'b0;
        end else if (clear_disable) begin
            over_cnt       <= '0;
            safety_disable <= 1'b0;
        end else if (!enable_check || !over_limit) begin
            over_cnt <= '0;                 // run broken, start over
        end else if (over_cnt == TRIP_CNT) begin
            safety_disable <= 1'b1;         // held until host clears
        end else begin
            over_cnt <= over_cnt + 1'b1;
        end
    end

endmodule

//--- src/reg_write_decode.sv
`include "qla_params.svh"

module reg_write_decode (
    input  logic                     sysclk,
    input  logic                     rst_n,
    input  logic                     reg_wen,      // one cycle per write
    input  logic                     blk_wen,      // write is part of a block
    input  logic [`QLA_ADDR_W-1:0]   reg_waddr,
    input  logic                     dac_busy,     // dac engine still shifting
    output logic [`QLA_NUM_CHAN-1:0] dac_wen,      // per axis, DAC_CTRL
    output logic [`QLA_NUM_CHAN-1:0] cfg_wen,      // per axis, MOTOR_CONFIG
    output logic                     dac_update    // one cycle, load the dacs
);

    logic [`QLA_FIELD_W-1:0]  space;
    logic [`QLA_FIELD_W-1:0]  chan;
    logic [`QLA_FIELD_W-1:0]  offset;
    logic                     wr_main;      // write into main space
    logic [`QLA_NUM_CHAN-1:0] chan_hit;     // one-hot axis select
    logic                     dac_req;      // update pending
    logic                     dac_grant;

    // ---------------------------------------------------------------------
    // address decode
    // ---------------------------------------------------------------------
    assign space   = reg_waddr[`QLA_SPACE_RNG];
    assign chan    = reg_waddr[`QLA_CHAN_RNG];
    assign offset  = reg_waddr[`QLA_OFF_RNG];
    assign wr_main = reg_wen & (space == `QLA_ADDR_MAIN);

    // channel 0 is the board, axes start at 1
    always_comb begin
        for (int i = 0; i < `QLA_NUM_CHAN; i++) begin
            chan_hit[i] = (chan == `QLA_FIELD_W'(i + 1));
        end
    end

    // strobes, combinational from the bus
    assign dac_wen = (wr_main && offset == `QLA_OFF_DAC_CTRL) ?
                     chan_hit : '0;
    assign cfg_wen = (wr_main && offset == `QLA_OFF_MOTOR_CONFIG) ?
                     chan_hit : '0;

    // ---------------------------------------------------------------------
    // dac update request
    // ---------------------------------------------------------------------
    // only block writes trigger an update, so all axes of one
    // host packet go out together; single quadlet writes just
    // stage the command until the next block
    assign dac_grant = dac_req & ~dac_busy;

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            dac_req    <= 1'b0;
            dac_update <= 1'b0;
        end else begin
            if (blk_wen && |dac_wen) begin
                dac_req <= 1'b1;            // new command staged
            end else if (dac_grant) begin
                dac_req <= 1'b0;            // engine free, hand it over
            end
            dac_update <= dac_grant;        // pulse one cycle after grant
        end
    end

    // while dac_busy stays high the request just waits

endmodule

//--- src/qla_pkg.sv
`include "qla_params.svh"

package qla_pkg;

    // ---------------------------------------------------------------------
    // register word as written by the host
    // ---------------------------------------------------------------------
    // the same 32 bits mean a current command at DAC_CTRL
    // and a set of mode bits at MOTOR_CONFIG
    typedef union packed {
        struct packed {
            logic [`QLA_DATA_W-`QLA_CUR_W-1:0] rsvd;   // upper half ignored
            logic signed [`QLA_CUR_W-1:0]      cur_cmd; // two's complement
        } dac;
        struct packed {
            logic [`QLA_DATA_W-4:0] rsvd;   // reads back as zero
            logic cur_ctrl;                 // 1 current loop, 0 voltage
            logic disable_safety;           // debug only, skips the check
            logic amp_enable;               // host request to enable amp
        } cfg;
    } reg_word_u;

endpackage

//--- include/qla_params.svh
`ifndef QLA_PARAMS_SVH
`define QLA_PARAMS_SVH

// ---------------------------------------------------------------------
// board size and bus widths
// ---------------------------------------------------------------------
`define QLA_NUM_CHAN            4       // motor axes on the board
`define QLA_DATA_W              32      // register data word
`define QLA_ADDR_W              16      // register address
`define QLA_CUR_W               16      // current cmd and feedback words

// ---------------------------------------------------------------------
// register address fields
// ---------------------------------------------------------------------
`define QLA_FIELD_W             4       // each address field is a nibble
`define QLA_SPACE_RNG           15:12   // address space
`define QLA_CHAN_RNG            7:4     // 0 is the board, 1..N the axes
`define QLA_OFF_RNG             3:0     // register within a channel

`define QLA_ADDR_MAIN           4'h0    // main board register space

// offsets within a channel
`define QLA_OFF_STATUS          4'h0    // board status, channel 0 only
`define QLA_OFF_DAC_CTRL        4'h1    // commanded current
`define QLA_OFF_MOTOR_STATUS    4'hC    // read only
`define QLA_OFF_MOTOR_CONFIG    4'hD    // amp enable, safety, mode

// ---------------------------------------------------------------------
// motor current safety check
// ---------------------------------------------------------------------
// trip when |fb| > 2*|cmd| + margin for COUNT samples in a row
`define QLA_SAFETY_MARGIN       200     // adc counts
`define QLA_SAFETY_LIM_W        19      // room for 2*32768 + margin
`define QLA_SAFETY_COUNT        8       // consecutive samples to trip
`define QLA_SAFETY_CNT_W        4       // run counter width

`endif
